// File: vita_conv_patterns.hex
// record count, then per record: settings word, input length, input words,
// expected length, expected words (36 bits each, flag nibble first)
6
// 1: even sample count, stream id and both timestamps, scale 0x400
00040400 9
010530009 012345678 000000064 000000000 000000010 01234ff00 000807f00 0c0f00101 0006080ff
8 114530008 012345678 000000064 000000000 000000010 0007f12ff 00181c101 200400000
// 2: odd sample count with an input trailer
00040400 5
004040005 00500fe80 000fc0080 03f7fffff 0000a0003
4 104040004 0010105fe 000003fff 2004a0403
// 3: scale 0x8000, saturation then a constant run that shows the error feedback
00048000 6
000050006 070009000 00005fffb 00005fffb 00005fffb 00400fc00
5 104050005 001007f80 0010000ff 000007f80 200400400
// 4: context packet with convert on, payload untouched
00040400 4
090060004 000001111 0abcd0123 07fff8000
4 190060004 000001111 0abcd0123 07fff8000
// 5: IF packet with convert off
00000400 4
004070004 01234abcd 080007fff 000000001
4 104070004 01234abcd 080007fff 000000001
// 6: convert on again, rounding error carried over from record 3
00040400 3
000080003 0001000f0 0ffa30000
3 104080003 000000001 200400000

// File: sources.f
vita_conv_pkg.sv
buffer_access_if.sv
setting_reg.sv
pipe_ctrl.sv
scale_clip_round.sv
dsp_engine_16to8.sv
packet_buffer.sv
vita_conv_top.sv
tb_vita_conv.sv

// File: tb_vita_conv.sv
/*
 * self-checking testbench for vita_conv_top
 * records come from vita_conv_patterns.hex, opened relative to the run directory
 * the rounding error is never reset between records, so record order matters
 */
`timescale 1ns/1ps
`default_nettype none

module tb_vita_conv;

   localparam int BUF_AW   = 9;
   localparam int SET_ADDR = 0;
   localparam int PAT_SIZE = 256;

   logic              clk;
   logic              rst_n_i;
   logic              set_stb_i;
   logic [7:0]        set_addr_i;
   logic [31:0]       set_data_i;
   logic              host_we_i;
   logic [BUF_AW-1:0] host_adr_i;
   logic [35:0]       host_dat_i;
   logic [35:0]       host_dat_o;
   logic [15:0]       host_len_i;
   logic              host_go_i;
   logic              busy_o;
   logic              done_o;

   logic [35:0] pat [PAT_SIZE];
   int          err_cnt = 0;
   int          check_cnt = 0;
   int          done_cnt = 0;
   int          watchdog_cycles = 0;

   vita_conv_top #(
      .BUF_AW   (BUF_AW),
      .SET_ADDR (SET_ADDR)
   ) dut_i (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .host_we_i  (host_we_i),
      .host_adr_i (host_adr_i),
      .host_dat_i (host_dat_i),
      .host_dat_o (host_dat_o),
      .host_len_i (host_len_i),
      .host_go_i  (host_go_i),
      .busy_o     (busy_o),
      .done_o     (done_o)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk)
   begin
      if (done_o === 1'b1)
         done_cnt <= done_cnt + 1;
   end

   initial
   begin
      wait (watchdog_cycles > 0);
      repeat (watchdog_cycles) @(posedge clk);
      $display("watchdog expired after %0d cycles, the run did not complete", watchdog_cycles);
      $display("=== FAIL ===");
      $finish;
   end

   // inputs change 1 ns after the edge, outputs are sampled there too
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic write_setting(input logic [31:0] word);
      next_cycle();
      set_stb_i  = 1'b1;
      set_addr_i = 8'(SET_ADDR);
      set_data_i = word;
      next_cycle();
      set_stb_i  = 1'b0;
   endtask

   task automatic load_packet(input int base, input int len);
      int i;
      for (i = 0; i < len; i++)
      begin
         next_cycle();
         host_we_i  = 1'b1;
         host_adr_i = i[BUF_AW-1:0];
         host_dat_i = pat[base + i];
      end
      next_cycle();
      host_we_i = 1'b0;
   endtask

   task automatic start_packet(input int len);
      next_cycle();
      host_go_i  = 1'b1;
      host_len_i = len[15:0];
      next_cycle();
      host_go_i  = 1'b0;
      check_cnt++;
      if (busy_o !== 1'b1)
      begin
         err_cnt++;
         $display("MISMATCH busy_o after go: got %h expected 1", busy_o);
      end
   endtask

   task automatic wait_done(input int limit, output logic timed_out);
      int   cycles;
      logic seen;
      cycles    = 0;
      seen      = 1'b0;
      timed_out = 1'b0;
      while (!seen && !timed_out)
      begin
         next_cycle();
         cycles++;
         if (busy_o !== 1'b1)
         begin
            err_cnt++;
            $display("MISMATCH busy_o before done: got %h expected 1", busy_o);
         end
         if (done_o === 1'b1)
            seen = 1'b1;
         else if (cycles >= limit)
            timed_out = 1'b1;
      end
   endtask

   task automatic read_word(input int adr, output logic [35:0] word);
      next_cycle();
      host_adr_i = adr[BUF_AW-1:0];
      next_cycle();
      word = host_dat_o;
   endtask

   initial
   begin
      int          ptr;
      int          rec;
      int          n_rec;
      int          in_len;
      int          exp_len;
      int          i;
      logic        aborted;
      logic [35:0] got;

      rst_n_i    = 1'b0;
      set_stb_i  = 1'b0;
      set_addr_i = '0;
      set_data_i = '0;
      host_we_i  = 1'b0;
      host_adr_i = '0;
      host_dat_i = '0;
      host_len_i = '0;
      host_go_i  = 1'b0;
      aborted    = 1'b0;

      $readmemh("vita_conv_patterns.hex", pat);
      n_rec = pat[0];
      if (n_rec == 0)
      begin
         err_cnt++;
         $display("pattern file is missing or holds no records");
      end

      // walk the records once to size the watchdog
      ptr = 1;
      for (rec = 0; rec < n_rec; rec++)
      begin
         in_len  = pat[ptr + 1];
         ptr     = ptr + 2 + in_len;
         exp_len = pat[ptr];
         ptr     = ptr + 1 + exp_len;
      end
      watchdog_cycles = ptr * 20;

      repeat (2) @(posedge clk);
      #1;
      rst_n_i = 1'b1;
      check_cnt++;
      if (busy_o !== 1'b0 || done_o !== 1'b0)
      begin
         err_cnt++;
         $display("MISMATCH busy_o/done_o after reset: got %h/%h expected 0/0", busy_o, done_o);
      end

      ptr = 1;
      rec = 0;
      while (rec < n_rec && !aborted)
      begin
         write_setting(pat[ptr][31:0]);
         in_len = pat[ptr + 1];
         ptr    = ptr + 2;
         load_packet(ptr, in_len);
         ptr = ptr + in_len;
         start_packet(in_len);
         wait_done(in_len * 16 + 32, aborted);
         if (aborted)
         begin
            err_cnt++;
            $display("timed out waiting for done_o on record %0d", rec + 1);
         end
         else
         begin
            next_cycle();
            check_cnt++;
            if (busy_o !== 1'b0 || done_o !== 1'b0)
            begin
               err_cnt++;
               $display("MISMATCH busy_o/done_o after done: got %h/%h expected 0/0",
                        busy_o, done_o);
            end
            check_cnt++;
            if (done_cnt != rec + 1)
            begin
               err_cnt++;
               $display("MISMATCH done_o pulse count: got %h expected %h", done_cnt, rec + 1);
            end
            exp_len = pat[ptr];
            ptr     = ptr + 1;
            for (i = 0; i < exp_len; i++)
            begin
               read_word(i, got);
               check_cnt++;
               if (got !== pat[ptr + i])
               begin
                  err_cnt++;
                  $display("MISMATCH host_dat_o record %0d word %0d: got %h expected %h",
                           rec + 1, i, got, pat[ptr + i]);
               end
            end
            ptr = ptr + exp_len;
         end
         rec++;
      end

      $display("records: %0d  checks: %0d  errors: %0d", rec, check_cnt, err_cnt);
      if (err_cnt == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire

// File: vita_conv_top.sv
/*
 * 16-to-8 bit VITA-49 converter with its packet buffer
 * load the packet, pulse go with the length, wait for done
 */
`timescale 1ns/1ps
`default_nettype none

module vita_conv_top #(
   parameter int BUF_AW   = 9,
   parameter int SET_ADDR = 0
) (
   input  wire                           clk,
   input  wire                           rst_n_i,
   input  wire                           set_stb_i,
   input  wire [7:0]                     set_addr_i,
   input  wire [31:0]                    set_data_i,
   input  wire                           host_we_i,
   input  wire [BUF_AW-1:0]              host_adr_i,
   input  wire vita_conv_pkg::buf_word_t host_dat_i,
   output vita_conv_pkg::buf_word_t      host_dat_o,
   input  wire [15:0]                    host_len_i,
   input  wire                           host_go_i,
   output logic                          busy_o,
   output logic                          done_o
);

   logic                              convert;
   logic [vita_conv_pkg::SCALE_W-1:0] scale;

   buffer_access_if #(.BUF_AW(BUF_AW)) acc_if ();

   setting_reg #(.SET_ADDR(SET_ADDR)) u_settings (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .convert_o  (convert),
      .scale_o    (scale)
   );

   packet_buffer #(.BUF_AW(BUF_AW)) u_buffer (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .host_we_i  (host_we_i),
      .host_adr_i (host_adr_i),
      .host_dat_i (host_dat_i),
      .host_dat_o (host_dat_o),
      .host_len_i (host_len_i),
      .host_go_i  (host_go_i),
      .busy_o     (busy_o),
      .done_o     (done_o),
      .acc        (acc_if.buffer)
   );

   dsp_engine_16to8 #(.BUF_AW(BUF_AW)) u_engine (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .convert_i (convert),
      .scale_i   (scale),
      .acc       (acc_if.engine)
   );

endmodule

`default_nettype wire

// File: packet_buffer.sv
/*
 * single-port packet RAM shared by host and engine
 * the engine owns the port from go until its done pulse
 * host writes and go are illegal while busy
 */
`timescale 1ns/1ps
`default_nettype none

module packet_buffer #(
   parameter int BUF_AW = 9
) (
   input  wire                       clk,
   input  wire                       rst_n_i,
   input  wire                       host_we_i,
   input  wire [BUF_AW-1:0]          host_adr_i,
   input  wire vita_conv_pkg::buf_word_t host_dat_i,
   output vita_conv_pkg::buf_word_t  host_dat_o,
   input  wire [15:0]                host_len_i,
   input  wire                       host_go_i,
   output logic                      busy_o,
   output logic                      done_o,
   buffer_access_if.buffer           acc
);

   vita_conv_pkg::buf_word_t mem [2**BUF_AW];
   vita_conv_pkg::buf_word_t ram_wdat;
   vita_conv_pkg::buf_word_t rdat_q;
   logic [BUF_AW-1:0]        ram_adr;
   logic                     ram_we;
   logic                     ok_q;
   logic [15:0]              len_q;

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         ok_q <= 1'b0;
      else if (host_go_i)
         ok_q <= 1'b1;
      else if (acc.done)
         ok_q <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (host_go_i)
         len_q <= host_len_i;
   end

   // port goes to the engine while a packet is in flight
   assign ram_adr  = ok_q ? acc.adr  : host_adr_i;
   assign ram_we   = ok_q ? acc.we   : host_we_i;
   assign ram_wdat = ok_q ? acc.wdat : host_dat_i;

   always_ff @(posedge clk)
   begin
      if (ram_we)
         mem[ram_adr] <= ram_wdat;
      rdat_q <= mem[ram_adr];
   end

   assign acc.rdat   = rdat_q;
   assign acc.ok     = ok_q;
   assign acc.len    = len_q;
   assign host_dat_o = rdat_q;
   assign busy_o     = ok_q;
   assign done_o     = acc.done;

   host_idle_while_busy : assert property (@(posedge clk) disable iff (!rst_n_i)
      busy_o |-> !host_we_i && !host_go_i);

endmodule

`default_nettype wire

// File: dsp_engine_16to8.sv
/*
 * in-place 16-to-8 bit conversion of one VITA-49 packet
 * two output pairs per word, first pair in the low half
 * a zero-sample IF packet is not handled
 */
`timescale 1ns/1ps
`default_nettype none

module dsp_engine_16to8 #(
   parameter int BUF_AW = 9
) (
   input  wire                                clk,
   input  wire                                rst_n_i,
   input  wire                                convert_i,
   input  wire  [vita_conv_pkg::SCALE_W-1:0]  scale_i,
   buffer_access_if.engine                    acc
);

   vita_conv_pkg::engine_state_e state;
   vita_conv_pkg::vita_word_u    rd_w;

   logic [3:0]        hdr_len;
   logic              is_if_data;
   logic [BUF_AW-1:0] read_adr;
   logic [BUF_AW-1:0] write_adr;
   logic              even;
   logic              trl_reg;
   logic              wait_trl;
   logic [31:0]       new_hdr;
   logic [31:0]       new_trl;
   logic [31:0]       trl_mask;
   logic              last;
   logic [3:0]        stb;
   logic [1:0]        tag_out;
   logic              last_o;
   logic              even_o;
   logic              stb_out;
   logic              stb_read;
   logic              stb_write;
   logic              send_to_pipe;
   logic              wr_hdr;
   logic              wr_trl;
   logic              wr_any;
   logic [7:0]        i8;
   logic [7:0]        q8;
   logic [7:0]        i8_reg;
   logic [7:0]        q8_reg;

   assign rd_w = acc.rdat[31:0];

   // class id and fractional seconds take two words each
   assign is_if_data = (rd_w.hdr.pkt_type == 3'b000);
   assign hdr_len = 4'd1 + {3'd0, rd_w.hdr.sid_present} + {2'd0, rd_w.hdr.cid_present, 1'b0}
                    + {3'd0, |rd_w.hdr.tsi} + {2'd0, |rd_w.hdr.tsf, 1'b0};

   // the last sample sits just before the trailer, if any
   assign last = (16'(read_adr) + 16'd1) == (acc.len - 16'(trl_reg));

   assign last_o       = tag_out[1];
   assign even_o       = tag_out[0];
   assign stb_read     = stb[0];
   assign stb_write    = stb_out && (even_o || last_o);
   assign send_to_pipe = !stb_write && (state == vita_conv_pkg::ST_CONVERT);

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state     <= vita_conv_pkg::ST_IDLE;
         read_adr  <= '0;
         write_adr <= '0;
         even      <= 1'b0;
         trl_reg   <= 1'b0;
         wait_trl  <= 1'b0;
         new_hdr   <= '0;
         new_trl   <= '0;
         trl_mask  <= '0;
      end
      else
      begin
         case (state)
            vita_conv_pkg::ST_IDLE:
            begin
               read_adr  <= '0;
               write_adr <= '0;
               even      <= 1'b0;
               if (acc.ok)
                  state <= vita_conv_pkg::ST_PARSE_HEADER;
            end
            vita_conv_pkg::ST_PARSE_HEADER:
            begin
               trl_reg <= rd_w.hdr.trl_present;
               new_hdr <= {rd_w[31:16], acc.len};
               if (is_if_data && convert_i)
               begin
                  read_adr  <= BUF_AW'(hdr_len);
                  write_adr <= BUF_AW'(hdr_len);
                  state     <= vita_conv_pkg::ST_CONVERT;
               end
               else
                  state <= vita_conv_pkg::ST_WRITE_HEADER;
            end
            vita_conv_pkg::ST_CONVERT:
            begin
               // every converted packet gets a trailer
               new_hdr[26] <= 1'b1;
               if (stb_write)
                  write_adr <= write_adr + 1'b1;
               else if (stb_read)
               begin
                  read_adr <= read_adr + 1'b1;
                  even     <= !even;
                  if (last)
                  begin
                     state    <= vita_conv_pkg::ST_DRAIN;
                     trl_mask <= even ? vita_conv_pkg::TRAILER_EVEN_MASK
                                      : vita_conv_pkg::TRAILER_ODD_MASK;
                  end
               end
            end
            vita_conv_pkg::ST_DRAIN:
            begin
               if (stb_write)
               begin
                  write_adr <= write_adr + 1'b1;
                  if (last_o && trl_reg)
                  begin
                     wait_trl <= 1'b0;
                     state    <= vita_conv_pkg::ST_READ_TRAILER;
                  end
                  else if (last_o)
                  begin
                     new_trl <= trl_mask;
                     state   <= vita_conv_pkg::ST_WRITE_TRAILER;
                  end
               end
            end
            vita_conv_pkg::ST_READ_TRAILER:
            begin
               // read_adr already points at the old trailer, wait one read
               wait_trl <= 1'b1;
               new_trl  <= acc.rdat[31:0] | trl_mask;
               if (wait_trl)
                  state <= vita_conv_pkg::ST_WRITE_TRAILER;
            end
            vita_conv_pkg::ST_WRITE_TRAILER:
            begin
               new_hdr[15:0] <= 16'(write_adr) + 16'd1;
               write_adr     <= '0;
               state         <= vita_conv_pkg::ST_WRITE_HEADER;
            end
            vita_conv_pkg::ST_WRITE_HEADER:
               state <= vita_conv_pkg::ST_DONE;
            vita_conv_pkg::ST_DONE:
            begin
               read_adr  <= '0;
               write_adr <= '0;
               state     <= vita_conv_pkg::ST_IDLE;
            end
         endcase
      end
   end

   assign wr_hdr = (state == vita_conv_pkg::ST_WRITE_HEADER);
   assign wr_trl = (state == vita_conv_pkg::ST_WRITE_TRAILER);
   assign wr_any = wr_hdr || wr_trl || stb_write;

   assign acc.we   = wr_any;
   assign acc.adr  = wr_any ? write_adr : read_adr;
   assign acc.done = (state == vita_conv_pkg::ST_DONE);

   always_comb
   begin
      if (wr_hdr)
         acc.wdat = {vita_conv_pkg::FLAG_HEADER, new_hdr};
      else if (wr_trl)
         acc.wdat = {vita_conv_pkg::FLAG_TRAILER, new_trl};
      else if (last_o && !even_o)
         acc.wdat = {vita_conv_pkg::FLAG_DATA, 16'd0, i8, q8};
      else
         acc.wdat = {vita_conv_pkg::FLAG_DATA, i8, q8, i8_reg, q8_reg};
   end

   pipe_ctrl u_pipe (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .in_stb_i    (send_to_pipe),
      .tag_i       ({last, even}),
      .stage_stb_o (stb),
      .out_stb_o   (stb_out),
      .tag_o       (tag_out)
   );

   // hold the first pair until its partner comes out
   always_ff @(posedge clk)
   begin
      if (stb_out && !even_o)
         {i8_reg, q8_reg} <= {i8, q8};
   end

   scale_clip_round u_chan_i (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .sample_i    (rd_w.smp.i16),
      .scale_i     (scale_i),
      .mult_stb_i  (stb[1]),
      .clip_stb_i  (stb[2]),
      .round_stb_i (stb[3]),
      .sample_o    (i8)
   );

   scale_clip_round u_chan_q (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .sample_i    (rd_w.smp.q16),
      .scale_i     (scale_i),
      .mult_stb_i  (stb[1]),
      .clip_stb_i  (stb[2]),
      .round_stb_i (stb[3]),
      .sample_o    (q8)
   );

   no_write_in_idle : assert property (@(posedge clk) disable iff (!rst_n_i)
      (state == vita_conv_pkg::ST_IDLE) |-> !acc.we);

endmodule

`default_nettype wire

// File: scale_clip_round.sv
/*
 * one channel: signed multiply by scale, clip to 16 bits, round to 8
 * the rounding error carries over between samples and packets,
 * only reset clears it
 */
`timescale 1ns/1ps
`default_nettype none

module scale_clip_round (
   input  wire                                clk,
   input  wire                                rst_n_i,
   input  wire  [15:0]                        sample_i,
   input  wire  [vita_conv_pkg::SCALE_W-1:0]  scale_i,
   input  wire                                mult_stb_i,
   input  wire                                clip_stb_i,
   input  wire                                round_stb_i,
   output logic [7:0]                         sample_o
);

   logic signed [35:0] prod_q;
   logic        [23:0] prod_hi;
   logic        [15:0] clip_q;
   logic        [7:0]  err_q;
   logic signed [16:0] rnd_sum;
   logic               rnd_ovf;

   // sample padded with two zeros fills the 18-bit multiplier input
   always_ff @(posedge clk)
   begin
      if (mult_stb_i)
         prod_q <= $signed(scale_i) * $signed({sample_i, 2'b00});
   end

   assign prod_hi = prod_q[35:12];

   // saturate when the bits above 15 are not all sign copies
   always_ff @(posedge clk)
   begin
      if (clip_stb_i)
      begin
         if (&prod_hi[23:15] || ~|prod_hi[23:15])
            clip_q <= prod_hi[15:0];
         else if (prod_hi[23])
            clip_q <= 16'h8000;
         else
            clip_q <= 16'h7fff;
      end
   end

   // error feedback, the dropped low byte goes into the next sum
   assign rnd_sum = {clip_q[15], clip_q} + {9'd0, err_q};
   assign rnd_ovf = rnd_sum[16] ^ rnd_sum[15];

   always_ff @(posedge clk)
   begin
      if (round_stb_i)
         sample_o <= rnd_ovf ? 8'h7f : rnd_sum[15:8];
   end

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         err_q <= '0;
      else if (round_stb_i)
         err_q <= rnd_sum[7:0];
   end

endmodule

`default_nettype wire

// File: pipe_ctrl.sv
/*
 * four-stage strobe pipeline with a 2-bit tag per sample
 * there is no back-pressure, so the last stage is always accepted
 */
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl (
   input  wire         clk,
   input  wire         rst_n_i,
   input  wire         in_stb_i,
   input  wire  [1:0]  tag_i,
   output logic [3:0]  stage_stb_o,
   output logic        out_stb_o,
   output logic [1:0]  tag_o
);

   logic [3:0] valid;
   logic [1:0] tag_q [4];

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         valid <= '0;
      else
         valid <= {valid[2:0], in_stb_i};
   end

   // the tag of each stage travels with its valid bit
   always_ff @(posedge clk)
   begin
      tag_q[0] <= tag_i;
      tag_q[1] <= tag_q[0];
      tag_q[2] <= tag_q[1];
      tag_q[3] <= tag_q[2];
   end

   // stage 0 strobe is the read itself
   assign stage_stb_o = {valid[2:0], in_stb_i};
   assign out_stb_o   = valid[3];
   assign tag_o       = tag_q[3];

   // the last sample of a packet leaves an empty pipeline behind it
   last_leaves_alone : assert property (@(posedge clk) disable iff (!rst_n_i)
      (out_stb_o && tag_o[1]) |-> (valid[2:0] == 3'b000));

endmodule

`default_nettype wire

// File: setting_reg.sv
/*
 * convert flag and scale factor, written over the settings bus
 * bit 18 is convert, bits 17:0 the scale; one cycle of latency
 */
`timescale 1ns/1ps
`default_nettype none

module setting_reg #(
   parameter int SET_ADDR = 0
) (
   input  wire                                clk,
   input  wire                                rst_n_i,
   input  wire                                set_stb_i,
   input  wire [7:0]                          set_addr_i,
   input  wire [31:0]                         set_data_i,
   output logic                               convert_o,
   output logic [vita_conv_pkg::SCALE_W-1:0]  scale_o
);

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         convert_o <= 1'b0;
         scale_o   <= '0;
      end
      else if (set_stb_i && (set_addr_i == 8'(SET_ADDR)))
      begin
         convert_o <= set_data_i[18];
         scale_o   <= set_data_i[17:0];
      end
   end

endmodule

`default_nettype wire

// File: buffer_access_if.sv
/*
 * engine side access to the packet buffer
 * reads are synchronous, rdat follows adr by one cycle
 */
`timescale 1ns/1ps
`default_nettype none

interface buffer_access_if #(
   parameter int BUF_AW = 9
);

   logic                     ok;
   logic [15:0]              len;
   logic [BUF_AW-1:0]        adr;
   logic                     we;
   vita_conv_pkg::buf_word_t wdat;
   vita_conv_pkg::buf_word_t rdat;
   logic                     done;

   modport engine (input ok, input len, input rdat, output adr, output we, output wdat,
                   output done);

   modport buffer (output ok, output len, output rdat, input adr, input we, input wdat,
                   input done);

endinterface

`default_nettype wire

// File: vita_conv_pkg.sv
/*
 * shared layout for the 16-to-8 VITA-49 converter
 * a buffer word carries a 4-bit flag code above a 32-bit payload
 * only packet type 0 is treated as IF data
 */
`default_nettype none

package vita_conv_pkg;

   localparam int SCALE_W = 18;

   typedef logic [35:0] buf_word_t;

   // VITA-49 header word, msb first
   typedef struct packed {
      logic [2:0]  pkt_type;
      logic        sid_present;
      logic        cid_present;
      logic        trl_present;
      logic [1:0]  reserved;
      logic [1:0]  tsi;
      logic [1:0]  tsf;
      logic [3:0]  pkt_count;
      logic [15:0] pkt_len;
   } vita_hdr_t;

   // complex sample word, I in the upper half
   typedef struct packed {
      logic [15:0] i16;
      logic [15:0] q16;
   } vita_smp_t;

   typedef union packed {
      vita_hdr_t hdr;
      vita_smp_t smp;
   } vita_word_u;

   localparam logic [3:0] FLAG_DATA    = 4'h0;
   localparam logic [3:0] FLAG_HEADER  = 4'h1;
   localparam logic [3:0] FLAG_TRAILER = 4'h2;

   // sample-frame enable at bit 22, its indicator at bit 10
   localparam logic [31:0] TRAILER_ODD_MASK  = 32'h0040_0400;
   localparam logic [31:0] TRAILER_EVEN_MASK = 32'h0040_0000;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_PARSE_HEADER,
      ST_CONVERT,
      ST_DRAIN,
      ST_READ_TRAILER,
      ST_WRITE_TRAILER,
      ST_WRITE_HEADER,
      ST_DONE
   } engine_state_e;

endpackage

`default_nettype wire
